/* hw/ldpc_code_pkg.sv */
package ldpc_code_pkg;

    // Circulant size Z of the quasi-cyclic code
    localparam int EXPANSION_FACTOR = 8;

    // Circulant blocks held per frame
    localparam int NUM_BLOCKS = 4;

    // One full frame of messages
    localparam int DEPTH = EXPANSION_FACTOR * NUM_BLOCKS;

    // Message RAM address width
    localparam int ADDR_W = $clog2(DEPTH);

    // One cyclic shift value, enough to index inside a block
    localparam int SHIFT_W = $clog2(EXPANSION_FACTOR);

    // Channel LLR word width
    localparam int LLR_W = 8;

    // Read skid buffer entries behind the RAM output register
    localparam int MAX_SKID = 4;

endpackage: ldpc_code_pkg

/* hw/ldpc_apb_pkg.sv */
package ldpc_apb_pkg;

    // Bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Control register, bit 0 starts a pass and always reads back as zero
    localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h00;
    localparam int CTRL_START_BIT = 0;

    // Read-only status
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h04;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_LOADED_BIT = 1;

    // Shift table, one word per circulant block
    localparam logic [APB_ADDR_W-1:0] REG_SHIFT_BASE = 8'h08;
    localparam int REG_SHIFT_STRIDE = 4;

endpackage: ldpc_apb_pkg

/* hw/llr_writer.sv */
`timescale 1ns/1ps

module llr_writer
    import ldpc_code_pkg::*;
(
    input  wire logic              i_clock,
    input  wire logic              i_reset,
    // Channel LLR stream, no back-pressure
    input  wire logic [LLR_W-1:0]  i_llr_data,
    input  wire logic              i_llr_valid,
    input  wire logic              i_pass_done,
    // Write port into the message RAM
    output      logic [ADDR_W-1:0] o_wr_addr,
    output      logic [LLR_W-1:0]  o_wr_data,
    output      logic              o_wr_valid,
    output      logic              o_frame_loaded
);

logic [ADDR_W-1:0] wr_count;
logic              last_word;

assign last_word = (wr_count == ADDR_W'(DEPTH - 1));

// Writes go straight to the RAM at the counter address
assign o_wr_addr  = wr_count;
assign o_wr_data  = i_llr_data;
assign o_wr_valid = i_llr_valid;

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        wr_count       <= '0;
        o_frame_loaded <= 1'b0;
    end else begin
        if (i_llr_valid == 1'b1) begin
            if (last_word == 1'b1) begin
                wr_count <= '0;
            end else begin
                wr_count <= wr_count + 1'b1;
            end
        end

        // A frame completing wins over the end of the previous pass
        if ((i_llr_valid == 1'b1) && (last_word == 1'b1)) begin
            o_frame_loaded <= 1'b1;
        end else if (i_pass_done == 1'b1) begin
            o_frame_loaded <= 1'b0;
        end
    end
end

endmodule: llr_writer

/* hw/message_ram.sv */
`timescale 1ns/1ps

module message_ram
    import ldpc_code_pkg::*;
#(
    parameter int WIDTH = LLR_W,
    parameter int DEPTH = ldpc_code_pkg::DEPTH
) (
    input  wire logic                     i_clock,
    input  wire logic                     i_reset,
    // Write port
    input  wire logic [$clog2(DEPTH)-1:0] i_wr_addr,
    input  wire logic [WIDTH-1:0]         i_wr_data,
    input  wire logic                     i_wr_valid,
    // Read address handshake
    input  wire logic [$clog2(DEPTH)-1:0] i_rd_addr,
    input  wire logic                     i_rd_addr_valid,
    output      logic                     o_addr_ready,
    // Read data stream
    output      logic [WIDTH-1:0]         o_out_data,
    output      logic                     o_out_valid,
    input  wire logic                     i_out_ready
);

localparam int CNT_W = $clog2(MAX_SKID + 1);
localparam int PTR_W = $clog2(MAX_SKID);

logic [WIDTH-1:0] mem [DEPTH];

// Registered read stage
logic [WIDTH-1:0] rd_data_q;
logic             rd_valid_q;

// Skid buffer storage and pointers
logic [WIDTH-1:0] skid_mem [MAX_SKID];
logic [PTR_W-1:0] in_ptr;
logic [PTR_W-1:0] out_ptr;

// Front counts words accepted but not yet popped, back counts words held in the skid
logic [CNT_W-1:0] front_count;
logic [CNT_W-1:0] front_next;
logic [CNT_W-1:0] back_count;
logic [CNT_W-1:0] back_next;

logic addr_accept;
logic out_pop;

function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(MAX_SKID - 1)) begin
        next_ptr = '0;
    end else begin
        next_ptr = ptr + 1'b1;
    end
endfunction

assign addr_accept = i_rd_addr_valid & o_addr_ready;
assign out_pop     = o_out_valid & i_out_ready;

always_ff @(posedge i_clock) begin
    if (i_wr_valid == 1'b1) begin
        mem[i_wr_addr] <= i_wr_data;
    end
end

// The array read lands in rd_data_q one cycle after the address is taken
always_ff @(posedge i_clock) begin
    if (addr_accept == 1'b1) begin
        rd_data_q <= mem[i_rd_addr];
    end
end

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        rd_valid_q <= 1'b0;
    end else begin
        rd_valid_q <= addr_accept;
    end
end

always_comb begin
    front_next = front_count;
    if (addr_accept == 1'b1) begin
        front_next = front_next + CNT_W'(1);
    end
    if (out_pop == 1'b1) begin
        front_next = front_next - CNT_W'(1);
    end
end

always_comb begin
    back_next = back_count;
    if (rd_valid_q == 1'b1) begin
        back_next = back_next + CNT_W'(1);
    end
    if (out_pop == 1'b1) begin
        back_next = back_next - CNT_W'(1);
    end
end

always_ff @(posedge i_clock) begin
    if (rd_valid_q == 1'b1) begin
        skid_mem[in_ptr] <= rd_data_q;
    end
end

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        o_addr_ready <= 1'b0;
        o_out_valid  <= 1'b0;
        front_count  <= '0;
        back_count   <= '0;
        in_ptr       <= '0;
        out_ptr      <= '0;
    end else begin
        front_count <= front_next;
        back_count  <= back_next;

        // Stop taking addresses once in-flight plus held words reach MAX_SKID - 1,
        // which leaves room for the word accepted while ready is still high
        o_addr_ready <= (front_next < CNT_W'(MAX_SKID - 1));
        o_out_valid  <= (back_next != '0);

        if (rd_valid_q == 1'b1) begin
            in_ptr <= next_ptr(in_ptr);
        end
        if (out_pop == 1'b1) begin
            out_ptr <= next_ptr(out_ptr);
        end
    end
end

// Head of the skid buffer
assign o_out_data = skid_mem[out_ptr];

endmodule: message_ram

/* hw/circulant_reader.sv */
`timescale 1ns/1ps

module circulant_reader
    import ldpc_code_pkg::*;
(
    input  wire logic                          i_clock,
    input  wire logic                          i_reset,
    input  wire logic                          i_start,
    input  wire logic [NUM_BLOCKS*SHIFT_W-1:0] i_shifts,
    input  wire logic                          i_frame_loaded,
    input  wire logic                          i_addr_ready,
    output      logic [ADDR_W-1:0]             o_rd_addr,
    output      logic                          o_rd_addr_valid,
    output      logic                          o_busy,
    output      logic                          o_pass_done
);

localparam int BLK_W = $clog2(NUM_BLOCKS);

logic [BLK_W-1:0]   block_cnt;
logic [SHIFT_W-1:0] index_cnt;
logic [SHIFT_W-1:0] shift_value;
logic [SHIFT_W-1:0] shifted_index;
logic               addr_accept;
logic               last_index;
logic               last_addr;

// Shift of the current block
assign shift_value = i_shifts[block_cnt*SHIFT_W +: SHIFT_W];

// SHIFT_W bits wrap the sum modulo EXPANSION_FACTOR
assign shifted_index = shift_value + index_cnt;

assign o_rd_addr = ADDR_W'(block_cnt * EXPANSION_FACTOR) + ADDR_W'(shifted_index);

// Armed but idle until the whole frame is in the RAM
assign o_rd_addr_valid = o_busy & i_frame_loaded;
assign addr_accept     = o_rd_addr_valid & i_addr_ready;

assign last_index = (index_cnt == SHIFT_W'(EXPANSION_FACTOR - 1));
assign last_addr  = last_index && (block_cnt == BLK_W'(NUM_BLOCKS - 1));

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        o_busy      <= 1'b0;
        o_pass_done <= 1'b0;
        block_cnt   <= '0;
        index_cnt   <= '0;
    end else begin
        o_pass_done <= addr_accept & last_addr;

        if (o_busy == 1'b0) begin
            // Start while busy is dropped here
            if (i_start == 1'b1) begin
                o_busy    <= 1'b1;
                block_cnt <= '0;
                index_cnt <= '0;
            end
        end else if (addr_accept == 1'b1) begin
            if (last_addr == 1'b1) begin
                o_busy    <= 1'b0;
                block_cnt <= '0;
                index_cnt <= '0;
            end else if (last_index == 1'b1) begin
                index_cnt <= '0;
                block_cnt <= block_cnt + 1'b1;
            end else begin
                index_cnt <= index_cnt + 1'b1;
            end
        end
    end
end

endmodule: circulant_reader

/* hw/shift_table_apb.sv */
`timescale 1ns/1ps

module shift_table_apb
    import ldpc_code_pkg::*;
    import ldpc_apb_pkg::*;
(
    input  wire logic                          i_clock,
    input  wire logic                          i_reset,
    // APB slave, zero wait states
    input  wire logic                          i_psel,
    input  wire logic                          i_penable,
    input  wire logic                          i_pwrite,
    input  wire logic [APB_ADDR_W-1:0]         i_paddr,
    input  wire logic [APB_DATA_W-1:0]         i_pwdata,
    output      logic [APB_DATA_W-1:0]         o_prdata,
    // Status inputs
    input  wire logic                          i_busy,
    input  wire logic                          i_frame_loaded,
    // Reader control
    output      logic [NUM_BLOCKS*SHIFT_W-1:0] o_shifts,
    output      logic                          o_start
);

logic [SHIFT_W-1:0] shift_q [NUM_BLOCKS];
logic               wr_en;
logic               rd_en;

function automatic logic [APB_ADDR_W-1:0] shift_addr(input int blk);
    shift_addr = APB_ADDR_W'(REG_SHIFT_BASE + REG_SHIFT_STRIDE * blk);
endfunction

// Writes commit in the access phase
assign wr_en = i_psel & i_penable & i_pwrite;
assign rd_en = i_psel & ~i_pwrite;

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        o_start <= 1'b0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            shift_q[b] <= '0;
        end
    end else begin
        o_start <= wr_en && (i_paddr == REG_CTRL) && (i_pwdata[CTRL_START_BIT] == 1'b1);
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if ((wr_en == 1'b1) && (i_paddr == shift_addr(b))) begin
                shift_q[b] <= i_pwdata[SHIFT_W-1:0];
            end
        end
    end
end

always_comb begin
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        o_shifts[b*SHIFT_W +: SHIFT_W] = shift_q[b];
    end
end

// Read mux, unmapped offsets and CTRL fall through to zero
always_comb begin
    o_prdata = '0;
    if (rd_en == 1'b1) begin
        if (i_paddr == REG_STATUS) begin
            o_prdata[STATUS_BUSY_BIT]   = i_busy;
            o_prdata[STATUS_LOADED_BIT] = i_frame_loaded;
        end
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (i_paddr == shift_addr(b)) begin
                o_prdata[SHIFT_W-1:0] = shift_q[b];
            end
        end
    end
end

endmodule: shift_table_apb

/* hw/ldpc_layer_buffer.sv */
`timescale 1ns/1ps

module ldpc_layer_buffer
    import ldpc_code_pkg::*;
    import ldpc_apb_pkg::*;
(
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    // Channel LLR input
    input  wire logic [LLR_W-1:0]      i_llr_data,
    input  wire logic                  i_llr_valid,
    // Host register access
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [APB_ADDR_W-1:0] i_paddr,
    input  wire logic [APB_DATA_W-1:0] i_pwdata,
    output      logic [APB_DATA_W-1:0] o_prdata,
    // Shifted layer output
    output      logic [LLR_W-1:0]      o_out_data,
    output      logic                  o_out_valid,
    input  wire logic                  i_out_ready
);

// Writer to RAM
logic [ADDR_W-1:0] wr_addr;
logic [LLR_W-1:0]  wr_data;
logic              wr_valid;
logic              frame_loaded;

// Reader to RAM
logic [ADDR_W-1:0] rd_addr;
logic              rd_addr_valid;
logic              addr_ready;

// Control between the register block and the reader
logic [NUM_BLOCKS*SHIFT_W-1:0] shifts;
logic                          start;
logic                          busy;
logic                          pass_done;

llr_writer u_writer (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_llr_data     (i_llr_data),
    .i_llr_valid    (i_llr_valid),
    .i_pass_done    (pass_done),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_wr_valid     (wr_valid),
    .o_frame_loaded (frame_loaded)
);

message_ram #(
    .WIDTH (LLR_W),
    .DEPTH (DEPTH)
) u_ram (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_wr_addr       (wr_addr),
    .i_wr_data       (wr_data),
    .i_wr_valid      (wr_valid),
    .i_rd_addr       (rd_addr),
    .i_rd_addr_valid (rd_addr_valid),
    .o_addr_ready    (addr_ready),
    .o_out_data      (o_out_data),
    .o_out_valid     (o_out_valid),
    .i_out_ready     (i_out_ready)
);

circulant_reader u_reader (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_start         (start),
    .i_shifts        (shifts),
    .i_frame_loaded  (frame_loaded),
    .i_addr_ready    (addr_ready),
    .o_rd_addr       (rd_addr),
    .o_rd_addr_valid (rd_addr_valid),
    .o_busy          (busy),
    .o_pass_done     (pass_done)
);

shift_table_apb u_regs (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_prdata       (o_prdata),
    .i_busy         (busy),
    .i_frame_loaded (frame_loaded),
    .o_shifts       (shifts),
    .o_start        (start)
);

endmodule: ldpc_layer_buffer

/* verification/ldpc_layer_buffer_tb.sv */
`timescale 1ns/1ps

module ldpc_layer_buffer_tb
    import ldpc_code_pkg::*;
    import ldpc_apb_pkg::*;
();

localparam int CLK_PERIOD      = 20;
localparam int RESET_CYCLES    = 10;
localparam int NUM_PASSES      = 8;
localparam int WATCHDOG_CYCLES = NUM_PASSES * DEPTH * 8 + 200;
localparam logic [31:0] SEED   = 32'd43081;

logic                  i_clock;
logic                  i_reset;
logic [LLR_W-1:0]      i_llr_data;
logic                  i_llr_valid;
logic                  i_psel;
logic                  i_penable;
logic                  i_pwrite;
logic [APB_ADDR_W-1:0] i_paddr;
logic [APB_DATA_W-1:0] i_pwdata;
logic [APB_DATA_W-1:0] o_prdata;
logic [LLR_W-1:0]      o_out_data;
logic                  o_out_valid;
logic                  i_out_ready;

// Reference model of the frame, the shift table and the output order
logic [LLR_W-1:0]   frame_words [DEPTH];
logic [SHIFT_W-1:0] shift_model [NUM_BLOCKS];
logic [LLR_W-1:0]   exp_queue [$];
logic [31:0]        data_rng;
logic               random_ready;
int                 check_count;
int                 error_count;
string              test_name;

ldpc_layer_buffer dut (.*);

initial begin
    i_clock = 1'b0;
    forever begin
        #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end
end

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state ^ (state << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

function automatic logic [APB_ADDR_W-1:0] shift_offset(input int blk);
    return APB_ADDR_W'(REG_SHIFT_BASE + REG_SHIFT_STRIDE * blk);
endfunction

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
        error_count++;
        $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
    end
endtask

// Zero-wait transfer with read data taken in the middle of the access phase
task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata);
    @(negedge i_clock);
    i_psel   = 1'b1;
    i_pwrite = write;
    i_paddr  = addr;
    i_pwdata = wdata;
    @(negedge i_clock);
    i_penable = 1'b1;
    #(CLK_PERIOD / 4);
    rdata = o_prdata;
    @(negedge i_clock);
    i_psel    = 1'b0;
    i_penable = 1'b0;
endtask

task automatic write_register(input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] data);
    logic [APB_DATA_W-1:0] ignored_data;
    apb_transfer(1'b1, addr, data, ignored_data);
endtask

task automatic expect_register(input string what, input logic [APB_ADDR_W-1:0] addr,
                               input logic [APB_DATA_W-1:0] expected);
    logic [APB_DATA_W-1:0] rdata;
    apb_transfer(1'b0, addr, '0, rdata);
    check_value(what, expected, rdata);
endtask

// New random words for frame positions first onward
task automatic send_words(input int first, input int count);
    for (int i = 0; i < count; i++) begin
        @(negedge i_clock);
        data_rng = xorshift32(data_rng);
        frame_words[first + i] = data_rng[LLR_W-1:0];
        i_llr_data  = data_rng[LLR_W-1:0];
        i_llr_valid = 1'b1;
    end
    @(negedge i_clock);
    i_llr_valid = 1'b0;
endtask

task automatic randomize_shifts();
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        data_rng = xorshift32(data_rng);
        shift_model[b] = data_rng[SHIFT_W-1:0];
    end
endtask

task automatic load_shifts();
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        write_register(shift_offset(b), APB_DATA_W'(shift_model[b]));
    end
endtask

// Block b at index k reads word b*Z + (shift_b + k) mod Z
task automatic queue_expected();
    int addr;
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        for (int k = 0; k < EXPANSION_FACTOR; k++) begin
            addr = b * EXPANSION_FACTOR + (int'(shift_model[b]) + k) % EXPANSION_FACTOR;
            exp_queue.push_back(frame_words[addr]);
        end
    end
endtask

task automatic finish_pass();
    while (exp_queue.size() != 0) begin
        @(negedge i_clock);
    end
    repeat (4) @(negedge i_clock);
    expect_register("STATUS after pass", REG_STATUS, '0);
endtask

task automatic run_pass();
    send_words(0, DEPTH);
    load_shifts();
    queue_expected();
    write_register(REG_CTRL, 32'h1);
    finish_pass();
endtask

// Output ready pattern and scoreboard
initial begin
    logic [31:0] ready_rng;
    int          stall_left;
    ready_rng   = SEED;
    stall_left  = 0;
    i_out_ready = 1'b1;
    forever begin
        @(negedge i_clock);
        ready_rng = xorshift32(ready_rng);
        if (random_ready == 1'b0) begin
            i_out_ready = 1'b1;
        end else if (stall_left != 0) begin
            i_out_ready = 1'b0;
            stall_left--;
        end else if (ready_rng[3:0] == 4'd0) begin
            // Long enough to fill the skid buffer and stall the reader
            i_out_ready = 1'b0;
            stall_left  = 8 + int'(ready_rng[7:4]);
        end else begin
            i_out_ready = ready_rng[8];
        end
        if ((o_out_valid === 1'b1) && (i_out_ready == 1'b1)) begin
            assert (exp_queue.size() != 0) else begin
                error_count++;
                $display("Output word 0x%0h appeared in %s while no word was due",
                         o_out_data, test_name);
            end
            if (exp_queue.size() != 0) begin
                check_value("output word", exp_queue.pop_front(), o_out_data);
            end
        end
    end
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
end

initial begin
    logic [APB_DATA_W-1:0] written [NUM_BLOCKS];
    i_reset      = 1'b1;
    i_llr_data   = '0;
    i_llr_valid  = 1'b0;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    i_pwrite     = 1'b0;
    i_paddr      = '0;
    i_pwdata     = '0;
    data_rng     = SEED;
    random_ready = 1'b0;
    check_count  = 0;
    error_count  = 0;
    test_name    = "reset_state";
    repeat (RESET_CYCLES) @(negedge i_clock);
    i_reset = 1'b0;
    @(negedge i_clock);

    check_value("o_out_valid after reset", '0, o_out_valid);
    expect_register("STATUS", REG_STATUS, '0);
    expect_register("CTRL", REG_CTRL, '0);
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        expect_register("shift after reset", shift_offset(b), '0);
    end

    test_name = "register_map";
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        data_rng   = xorshift32(data_rng);
        written[b] = data_rng;
        write_register(shift_offset(b), written[b]);
    end
    // Nothing outside the shift table may change
    write_register(8'h18, '1);
    write_register(8'h80, '1);
    write_register(REG_STATUS, '1);
    // Start bit low, every other CTRL bit high
    write_register(REG_CTRL, 32'hFFFF_FFFE);
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        expect_register("shift readback", shift_offset(b),
                        written[b] & APB_DATA_W'((1 << SHIFT_W) - 1));
    end
    expect_register("unmapped 0x18", 8'h18, '0);
    expect_register("unmapped 0x80", 8'h80, '0);
    expect_register("CTRL after write", REG_CTRL, '0);
    expect_register("STATUS after write", REG_STATUS, '0);

    test_name = "zero_shift";
    for (int b = 0; b < NUM_BLOCKS; b++) begin
        shift_model[b] = '0;
    end
    run_pass();

    test_name   = "fixed_shifts";
    shift_model = '{3, 7, 0, 5};
    run_pass();

    test_name    = "backpressure";
    random_ready = 1'b1;
    repeat (3) begin
        randomize_shifts();
        run_pass();
    end
    random_ready = 1'b0;

    test_name = "start_before_frame";
    randomize_shifts();
    load_shifts();
    write_register(REG_CTRL, 32'h1);
    expect_register("STATUS armed", REG_STATUS, 32'h1);
    send_words(0, DEPTH - 1);
    repeat (10) @(negedge i_clock);
    expect_register("STATUS partial frame", REG_STATUS, 32'h1);
    send_words(DEPTH - 1, 1);
    queue_expected();
    expect_register("STATUS during pass", REG_STATUS, 32'h3);
    finish_pass();

    test_name = "start_while_busy";
    randomize_shifts();
    load_shifts();
    send_words(0, DEPTH);
    queue_expected();
    write_register(REG_CTRL, 32'h1);
    write_register(REG_CTRL, 32'h1);
    expect_register("STATUS during pass", REG_STATUS, 32'h3);
    finish_pass();

    test_name = "second_pass";
    randomize_shifts();
    load_shifts();
    send_words(0, DEPTH);
    repeat (10) @(negedge i_clock);
    expect_register("STATUS loaded and idle", REG_STATUS, 32'h2);
    queue_expected();
    write_register(REG_CTRL, 32'h1);
    finish_pass();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule: ldpc_layer_buffer_tb

/* src.f */
hw/ldpc_code_pkg.sv
hw/ldpc_apb_pkg.sv
hw/llr_writer.sv
hw/message_ram.sv
hw/circulant_reader.sv
hw/shift_table_apb.sv
hw/ldpc_layer_buffer.sv
verification/ldpc_layer_buffer_tb.sv

/* run.sh */
#!/bin/sh
# Build the RTL and testbench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module ldpc_layer_buffer_tb -o ldpc_layer_buffer_sim \
    || { echo "Build failed"; exit 1; }

sim_output=$(./obj_dir/ldpc_layer_buffer_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "TB PASSED" && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
